// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = corr_link_tb
FILELIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+tests
design/corr_pkg.sv
design/corr_frame_serializer.sv
design/corr_bus_deserializer.sv
design/corr_peak_finder.sv
design/corr_link_top.sv
tests/corr_link_tb.sv

// ==== design/corr_bus_deserializer.sv ====
module corr_bus_deserializer
(
   input logic clk,
   input logic rst,
   input corr_pkg::bus_beat_t beat,
   output corr_pkg::corr_frame_t frame_out,
   output logic frame_strobe,
   output corr_pkg::scale_flags_t new_data
);

   corr_pkg::phase_t phase_q;
   corr_pkg::byte_t [corr_pkg::bus_words:1] words_q;
   corr_pkg::frame_stream_t asm_q;
   corr_pkg::frame_stream_t asm_next;
   corr_pkg::corr_frame_t assembled;
   corr_pkg::scale_flags_t flags;
   logic [5:0] wr_base;
   logic last_phase;

   // the bus is registered once before it is decoded.
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phase_q <= corr_pkg::phase_idle;
      end
      else
      begin
         phase_q <= beat.phase;
      end
   end

   always_ff @(posedge clk)
   begin
      words_q <= beat.words;
   end

   assign last_phase = (phase_q == corr_pkg::phase_last);

   // phase k fills stream bytes (k - 1) * 6 onward.
   assign wr_base = 6'((phase_q - 3'd1) * corr_pkg::bus_words);

   always_comb
   begin
      asm_next = asm_q;
      if (phase_q != corr_pkg::phase_idle)
      begin
         asm_next[wr_base +: corr_pkg::bus_words] = words_q;
      end
   end

   // unpack the byte stream into the frame fields.
   assign assembled.addr = {asm_next[2][7:5], asm_next[1], asm_next[0]};
   assign assembled.comp_switch = asm_next[2][4];
   assign assembled.s5 = asm_next[8:3];
   assign assembled.s10 = asm_next[19:9];
   assign assembled.s20 = asm_next[40:20];

   // each coarser scale needs the finer one plus two more zero address bits.
   always_comb
   begin
      flags.scale_1 = (assembled.addr[8:0] != 9'd0);
      flags.scale_2 = flags.scale_1 && !assembled.addr[0] && !assembled.addr[9];
      flags.scale_4 = flags.scale_2 && !assembled.addr[1] && !assembled.addr[10];
   end

   always_ff @(posedge clk)
   begin
      asm_q <= asm_next;
   end

   // the last phase goes straight into the published frame on the same edge.
   always_ff @(posedge clk)
   begin
      if (last_phase)
      begin
         frame_out <= assembled;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         frame_strobe <= 1'b0;
         new_data <= '0;
      end
      else if (last_phase)
      begin
         frame_strobe <= 1'b1;
         new_data <= flags;
      end
      else
      begin
         frame_strobe <= 1'b0;
         new_data <= '0;
      end
   end

endmodule

// ==== design/corr_frame_serializer.sv ====
module corr_frame_serializer
(
   input logic clk,
   input logic rst,
   input logic load,
   input corr_pkg::corr_frame_t frame,
   output logic busy,
   output corr_pkg::bus_beat_t beat
);

   corr_pkg::corr_frame_t frame_q;
   corr_pkg::frame_stream_t stream;
   corr_pkg::phase_t next_phase;
   logic [5:0] next_base;
   logic accept;

   // a new frame may start on the edge that retires the last phase.
   assign accept = load && (!busy || beat.phase == corr_pkg::phase_last);

   assign next_phase = beat.phase + 3'd1;

   // the next phase starts at byte phase * 6 of the stream.
   assign next_base = 6'(beat.phase * corr_pkg::bus_words);

   // bytes 1 to 3 carry the address and switch, then s5, s10, s20 and a pad byte.
   assign stream =
   {
      8'h00,
      frame_q.s20,
      frame_q.s10,
      frame_q.s5,
      {frame_q.addr[18:16], frame_q.comp_switch, 4'b0000},
      frame_q.addr[15:8],
      frame_q.addr[7:0]
   };

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         frame_q <= frame;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         beat <= '0;
      end
      else if (accept)
      begin
         busy <= 1'b1;
         beat <= '0;   // phase 1 follows on the next edge.
      end
      else if (busy)
      begin
         if (beat.phase == corr_pkg::phase_last)
         begin
            busy <= 1'b0;
            beat <= '0;
         end
         else
         begin
            beat.phase <= next_phase;
            beat.words <= stream[next_base +: corr_pkg::bus_words];
         end
      end
   end

endmodule

// ==== design/corr_link_top.sv ====
module corr_link_top
(
   input logic clk,
   input logic rst,
   input logic load,
   input corr_pkg::corr_frame_t frame_in,
   output logic busy,
   output corr_pkg::corr_frame_t frame_out,
   output corr_pkg::scale_flags_t new_data,
   output corr_pkg::peak_t peak_s5,
   output corr_pkg::peak_t peak_s10,
   output corr_pkg::peak_t peak_s20,
   output corr_pkg::scale_flags_t peak_valid
);

   corr_pkg::bus_beat_t bus;
   logic frame_strobe;   // pulses together with new_data.

   corr_frame_serializer corr_frame_serializer_i
   (
      .clk(clk),
      .rst(rst),
      .load(load),
      .frame(frame_in),
      .busy(busy),
      .beat(bus)
   );

   corr_bus_deserializer corr_bus_deserializer_i
   (
      .clk(clk),
      .rst(rst),
      .beat(bus),
      .frame_out(frame_out),
      .frame_strobe(frame_strobe),
      .new_data(new_data)
   );

   // scale 1 pairs with s5, scale 2 with s10 and scale 4 with s20.
   corr_peak_finder #(.vector_t(corr_pkg::corr_s5_t)) peak_s5_i
   (
      .clk(clk),
      .rst(rst),
      .start(new_data.scale_1),
      .vector(frame_out.s5),
      .peak(peak_s5),
      .peak_valid(peak_valid.scale_1)
   );

   corr_peak_finder #(.vector_t(corr_pkg::corr_s10_t)) peak_s10_i
   (
      .clk(clk),
      .rst(rst),
      .start(new_data.scale_2),
      .vector(frame_out.s10),
      .peak(peak_s10),
      .peak_valid(peak_valid.scale_2)
   );

   corr_peak_finder #(.vector_t(corr_pkg::corr_s20_t)) peak_s20_i
   (
      .clk(clk),
      .rst(rst),
      .start(new_data.scale_4),
      .vector(frame_out.s20),
      .peak(peak_s20),
      .peak_valid(peak_valid.scale_4)
   );

endmodule

// ==== design/corr_peak_finder.sv ====
module corr_peak_finder
#(
   parameter type vector_t = corr_pkg::corr_s5_t
)
(
   input logic clk,
   input logic rst,
   input logic start,
   input vector_t vector,
   output corr_pkg::peak_t peak,
   output logic peak_valid
);

   logic [$bits(vector_t)-1:0] flat;
   corr_pkg::peak_t scan;

   assign flat = vector;

   // strict compare keeps the lowest index on a tie.
   always_comb
   begin
      scan.index = 5'd0;
      scan.value = flat[7:0];
      for (int i = 1; i < $bits(vector_t) / 8; i++)
      begin
         if (flat[i * 8 +: 8] > scan.value)
         begin
            scan.index = 5'(i);
            scan.value = flat[i * 8 +: 8];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         peak <= scan;   // holds until the next start.
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         peak_valid <= 1'b0;
      end
      else
      begin
         peak_valid <= start;
      end
   end

endmodule

// ==== design/corr_pkg.sv ====
package corr_pkg;

   // bus geometry.
   localparam int bus_words = 6;   // bytes carried by one beat.
   localparam int phase_count = 7;   // the data phases of a frame run from 1 to 7.
   localparam int addr_width = 19;

   // phase 0 marks an idle bus.
   localparam logic [2:0] phase_idle = 3'd0;

   // phase 7 closes the frame.
   localparam logic [2:0] phase_last = 3'(phase_count);

   // 41 frame bytes plus one pad byte in the last phase.
   localparam int stream_bytes = bus_words * phase_count;

   typedef logic [7:0] byte_t;
   typedef logic [2:0] phase_t;

   // correlation vectors keep byte 0 in the low bits.
   typedef byte_t [5:0] corr_s5_t;
   typedef byte_t [10:0] corr_s10_t;
   typedef byte_t [20:0] corr_s20_t;

   // the frame as the port publishes it.
   typedef struct packed
   {
      logic [addr_width-1:0] addr;
      logic comp_switch;
      corr_s5_t s5;
      corr_s10_t s10;
      corr_s20_t s20;
   } corr_frame_t;

   // one bus beat carries word 1 in its low byte.
   typedef struct packed
   {
      phase_t phase;
      byte_t [bus_words:1] words;
   } bus_beat_t;

   // new-data strobes per scale.
   typedef struct packed
   {
      logic scale_1;
      logic scale_2;
      logic scale_4;
   } scale_flags_t;

   // disparity index and value of the largest correlation byte.
   typedef struct packed
   {
      logic [4:0] index;
      byte_t value;
   } peak_t;

   // the frame laid out in bus byte order.
   typedef byte_t [stream_bytes-1:0] frame_stream_t;

endpackage

// ==== tests/corr_link_cases.svh ====
`ifndef corr_link_cases_svh
`define corr_link_cases_svh

// each row holds an address, a switch bit, the expected flags {scale_1, scale_2, scale_4},
// a vector fill mode and a load timing.

localparam logic [1:0] fill_random = 2'd0;
localparam logic [1:0] fill_equal = 2'd1;   // every byte is the same, so the peak is at index 0.
localparam logic [1:0] fill_planted = 2'd2;   // largest byte at the last index.

localparam logic [1:0] time_single = 2'd0;
localparam logic [1:0] time_busy_load = 2'd1;   // an extra load arrives while busy.
localparam logic [1:0] time_back_to_back = 2'd2;   // second load on the earliest edge.

typedef struct packed
{
   logic [18:0] addr;
   logic comp_switch;
   corr_pkg::scale_flags_t flags;
   logic [1:0] fill;
   logic [1:0] timing;
} case_t;

localparam int num_cases = 11;

localparam case_t case_table [num_cases] = '{
   '{19'h00000, 1'b0, 3'b000, fill_random, time_single},
   '{19'h7fe00, 1'b1, 3'b000, fill_random, time_single},   // low nine bits zero.
   '{19'h00001, 1'b0, 3'b100, fill_random, time_single},
   '{19'h00002, 1'b1, 3'b110, fill_random, time_single},
   '{19'h00004, 1'b0, 3'b111, fill_planted, time_single},
   '{19'h00204, 1'b1, 3'b100, fill_equal, time_single},   // bit 9 stops scale 2.
   '{19'h00404, 1'b0, 3'b110, fill_random, time_single},   // bit 10 stops scale 4.
   '{19'h5a5fc, 1'b1, 3'b110, fill_planted, time_single},
   '{19'h7f008, 1'b1, 3'b111, fill_planted, time_busy_load},
   '{19'h60010, 1'b0, 3'b111, fill_equal, time_back_to_back},
   '{19'h2a820, 1'b1, 3'b111, fill_random, time_busy_load}
};

`endif

// ==== tests/corr_link_tb.sv ====
module corr_link_tb;

   timeunit 1ns;
   timeprecision 1ps;

   `include "corr_link_cases.svh"

   localparam int reset_cycles = 10;
   localparam int cycle_limit = num_cases * 12 + reset_cycles + 20;

   typedef logic [511:0] wide_t;
   typedef logic [$bits(corr_pkg::corr_s20_t)-1:0] vec_bits_t;

   logic clk = 1'b0;
   logic rst;
   logic load;
   corr_pkg::corr_frame_t frame_in;
   logic busy;
   corr_pkg::corr_frame_t frame_out;
   corr_pkg::scale_flags_t new_data;
   corr_pkg::peak_t peak_s5;
   corr_pkg::peak_t peak_s10;
   corr_pkg::peak_t peak_s20;
   corr_pkg::scale_flags_t peak_valid;

   logic [31:0] seed;
   int errors;
   int failed_cases;
   int cycles = 0;

   corr_link_top corr_link_top_i
   (
      .clk(clk),
      .rst(rst),
      .load(load),
      .frame_in(frame_in),
      .busy(busy),
      .frame_out(frame_out),
      .new_data(new_data),
      .peak_s5(peak_s5),
      .peak_s10(peak_s10),
      .peak_s20(peak_s20),
      .peak_valid(peak_valid)
   );

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic logic [7:0] next_byte();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[23:16];
   endfunction

   // the largest byte is found before the lowest index that holds it.
   function automatic corr_pkg::peak_t expected_peak(input vec_bits_t bytes, input int count);
      corr_pkg::peak_t p;
      p.value = 8'h00;
      p.index = 5'd0;
      for (int i = 0; i < count; i++)
      begin
         if (bytes[i * 8 +: 8] > p.value)
         begin
            p.value = bytes[i * 8 +: 8];
         end
      end
      for (int i = count - 1; i >= 0; i--)
      begin
         if (bytes[i * 8 +: 8] == p.value)
         begin
            p.index = 5'(i);
         end
      end
      return p;
   endfunction

   task automatic check_value(input string name, input wide_t got, input wide_t expected);
      if (got !== expected)
      begin
         errors++;
         $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
      end
   endtask

   task automatic fill_vector(input logic [1:0] fill, input int count, output vec_bits_t v);
      logic [7:0] same;
      same = next_byte();
      v = '0;
      for (int i = 0; i < count; i++)
      begin
         case (fill)
            fill_equal: v[i * 8 +: 8] = same;
            fill_planted: v[i * 8 +: 8] = next_byte() & 8'h7f;
            default: v[i * 8 +: 8] = next_byte();
         endcase
      end
      if (fill == fill_planted)
      begin
         v[(count - 1) * 8 +: 8] = 8'hc3;
      end
   endtask

   task automatic build_frame(input case_t c, input logic flip, output corr_pkg::corr_frame_t f);
      vec_bits_t v;
      f.addr = c.addr;
      f.comp_switch = c.comp_switch ^ flip;
      fill_vector(c.fill, 6, v);
      f.s5 = v[$bits(corr_pkg::corr_s5_t)-1:0];
      fill_vector(c.fill, 11, v);
      f.s10 = v[$bits(corr_pkg::corr_s10_t)-1:0];
      fill_vector(c.fill, 21, v);
      f.s20 = v;
   endtask

   task automatic check_idle();
      check_value("busy", wide_t'(busy), '0);
      check_value("frame_strobe", wide_t'(corr_link_top_i.frame_strobe), '0);
      check_value("new_data", wide_t'(new_data), '0);
      check_value("peak_valid", wide_t'(peak_valid), '0);
   endtask

   task automatic check_frame(input corr_pkg::corr_frame_t f);
      check_value("frame_out.addr", wide_t'(frame_out.addr), wide_t'(f.addr));
      check_value("frame_out.comp_switch", wide_t'(frame_out.comp_switch),
                  wide_t'(f.comp_switch));
      check_value("frame_out.s5", wide_t'(frame_out.s5), wide_t'(f.s5));
      check_value("frame_out.s10", wide_t'(frame_out.s10), wide_t'(f.s10));
      check_value("frame_out.s20", wide_t'(frame_out.s20), wide_t'(f.s20));
   endtask

   task automatic check_peaks(input corr_pkg::corr_frame_t f, input corr_pkg::scale_flags_t flags);
      if (flags.scale_1)
      begin
         check_value("peak_s5", wide_t'(peak_s5), wide_t'(expected_peak(vec_bits_t'(f.s5), 6)));
      end
      if (flags.scale_2)
      begin
         check_value("peak_s10", wide_t'(peak_s10),
                     wide_t'(expected_peak(vec_bits_t'(f.s10), 11)));
      end
      if (flags.scale_4)
      begin
         check_value("peak_s20", wide_t'(peak_s20), wide_t'(expected_peak(f.s20, 21)));
      end
   endtask

   // k counts edges from the one that accepts the load.
   task automatic run_case(input int idx);
      case_t c;
      logic b2b;
      logic strobe_now;
      logic peak_now;
      int busy_cycles;
      int span;
      int errors_before;
      corr_pkg::corr_frame_t first;
      corr_pkg::corr_frame_t second;
      corr_pkg::corr_frame_t dropped;
      c = case_table[idx];
      b2b = (c.timing == time_back_to_back);
      busy_cycles = b2b ? 16 : 8;
      span = b2b ? 18 : 10;
      errors_before = errors;
      build_frame(c, 1'b0, first);
      build_frame(c, 1'b1, second);
      build_frame(c, 1'b0, dropped);
      @(posedge clk);
      load <= 1'b1;
      frame_in <= first;
      for (int k = 0; k <= span; k++)
      begin
         @(posedge clk);
         if (c.timing == time_busy_load && k == 3)
         begin
            load <= 1'b1;   // lands in phase 3 and must be dropped.
            frame_in <= dropped;
         end
         else if (b2b && k == 7)
         begin
            load <= 1'b1;   // seen on the edge that retires phase 7.
            frame_in <= second;
         end
         else
         begin
            load <= 1'b0;
         end
         @(negedge clk);
         strobe_now = (k == 9) || (b2b && k == 17);
         peak_now = (k == 10) || (b2b && k == 18);
         check_value("busy", wide_t'(busy), wide_t'(k < busy_cycles));
         check_value("frame_strobe", wide_t'(corr_link_top_i.frame_strobe), wide_t'(strobe_now));
         check_value("new_data", wide_t'(new_data), strobe_now ? wide_t'(c.flags) : '0);
         check_value("peak_valid", wide_t'(peak_valid), peak_now ? wide_t'(c.flags) : '0);
         if (k == 9)
         begin
            check_frame(first);
         end
         if (k == 10)
         begin
            check_peaks(first, c.flags);
         end
         if (k == 17)
         begin
            check_frame(second);
         end
         if (k == 18)
         begin
            check_peaks(second, c.flags);
         end
      end
      if (errors != errors_before)
      begin
         failed_cases++;
      end
      $display("case %0d addr %h switch %b flags %b: %s", idx, c.addr, c.comp_switch, c.flags,
               (errors == errors_before) ? "ok" : "mismatch");
   endtask

   initial
   begin
      rst = 1'b1;
      load = 1'b0;
      frame_in = '0;
      seed = 32'h329cc925;
      errors = 0;
      failed_cases = 0;
      for (int i = 0; i < reset_cycles; i++)
      begin
         @(posedge clk);
         if (i == reset_cycles - 1)
         begin
            rst <= 1'b0;
         end
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      @(negedge clk);
      check_idle();
      $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
      for (int i = 0; i < num_cases; i++)
      begin
         run_case(i);
      end
      $display("cases %0d, failed %0d, errors %0d", num_cases, failed_cases, errors);
      if (errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
